//--- washer_pkg.sv
`default_nettype none

package washer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // programme and status types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MODE_STD   = 2'd0,
        MODE_QUICK = 2'd1,
        MODE_HEAVY = 2'd2                // 3 unused, runs as standard
    } mode_e;

    typedef logic [1:0] weight_t;        // 0..3 -> 1..4 load units

    typedef struct packed {
        mode_e   mode;
        weight_t weight;
    } settings_t;

    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_WASH  = 2'd1,
        PH_RINSE = 2'd2,
        PH_SPIN  = 2'd3
    } phase_e;

    typedef struct packed {
        logic wash_done;
        logic rinse_done;
        logic spin_done;
    } phase_end_t;                       // one-hot or zero, one cycle

    typedef struct packed {
        logic mode_btn;
        logic weight_btn;
        logic start_btn;
    } buttons_t;

    typedef struct packed {
        settings_t settings;
        phase_e    phase;
        logic      busy;
    } status_t;

    localparam settings_t SETTINGS_DEFAULT = '{mode: MODE_STD, weight: 2'd0};

    ////////////////////////////////////////////////////////////////////////////
    // phase durations in ticks
    ////////////////////////////////////////////////////////////////////////////

    localparam int DUR_W = 4;            // heavy at weight 3 is 12
    typedef logic [DUR_W-1:0] dur_t;

    localparam int KEY_BEEP_TICKS   = 2;
    localparam int PHASE_BEEP_TICKS = 6;

    function automatic dur_t wash_ticks(settings_t s);
        dur_t units;
        units = dur_t'(s.weight) + dur_t'(1);
        case (s.mode)
            MODE_QUICK: return units;
            MODE_HEAVY: return units * dur_t'(3);
            default:    return units << 1;      // standard and code 3
        endcase
    endfunction

    function automatic dur_t rinse_ticks(settings_t s);
        return dur_t'(s.weight) + dur_t'(2);
    endfunction

    function automatic dur_t spin_ticks(settings_t s);
        return (s.mode == MODE_QUICK) ? dur_t'(2) : dur_t'(3);
    endfunction

endpackage

`default_nettype wire

//--- washer_panel.sv
`timescale 1ns/1ps
`default_nettype none

module washer_panel (
    input  wire logic                  clk_src,
    input  wire logic                  arst_n,
    input  wire logic                  power,
    input  wire washer_pkg::buttons_t  btn,
    input  wire logic                  busy,
    output washer_pkg::settings_t      settings,
    output logic                       key_press,
    output logic                       start_cmd
);

    import washer_pkg::*;

    logic accept;                        // buttons are live
    logic any_setting;

    // standard -> quick -> heavy -> standard
    function automatic mode_e next_mode(mode_e m);
        case (m)
            MODE_STD:   return MODE_QUICK;
            MODE_QUICK: return MODE_HEAVY;
            MODE_HEAVY: return MODE_STD;
            default:    return MODE_QUICK;   // code 3 counts as standard
        endcase
    endfunction

    assign accept      = power && !busy;
    assign any_setting = btn.mode_btn || btn.weight_btn;

    ////////////////////////////////////////////////////////////////////////////
    // programme registers and key strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_src or negedge arst_n) begin
        if (!arst_n) begin
            settings  <= SETTINGS_DEFAULT;
            key_press <= 1'b0;
            start_cmd <= 1'b0;
        end else if (!power) begin
            settings  <= SETTINGS_DEFAULT;   // power loss forgets programme
            key_press <= 1'b0;
            start_cmd <= 1'b0;
        end else begin
            key_press <= 1'b0;
            start_cmd <= 1'b0;
            if (accept) begin
                if (btn.start_btn) begin
                    start_cmd <= 1'b1;       // start beats mode and weight
                    key_press <= 1'b1;
                end else if (any_setting) begin
                    key_press <= 1'b1;
                    if (btn.mode_btn) begin
                        settings.mode <= next_mode(settings.mode);
                    end
                    if (btn.weight_btn) begin
                        settings.weight <= settings.weight + 2'd1;   // wraps 3 -> 0
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- washer_phase_seq.sv
`timescale 1ns/1ps
`default_nettype none

module washer_phase_seq #(
    parameter int TICK_DIV = 8
) (
    input  wire logic                   clk_src,
    input  wire logic                   arst_n,
    input  wire logic                   power,
    input  wire logic                   start_cmd,
    input  wire washer_pkg::settings_t  settings,
    output washer_pkg::phase_e          phase,
    output logic                        busy,
    output logic                        tick,
    output washer_pkg::phase_end_t      phase_end
);

    import washer_pkg::*;

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    dur_t             remain;            // ticks left in this phase
    logic             last_tick;

    ////////////////////////////////////////////////////////////////////////////
    // tick prescaler
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_src or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (!power) begin
            div_cnt <= '0;               // restart from zero on power up
            tick    <= 1'b0;
        end else if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // phase timer
    ////////////////////////////////////////////////////////////////////////////

    assign last_tick = tick && (remain == dur_t'(1));
    assign busy      = (phase != PH_IDLE);

    always_ff @(posedge clk_src or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= PH_IDLE;
            remain    <= '0;
            phase_end <= '0;
        end else if (!power) begin
            phase     <= PH_IDLE;
            remain    <= '0;
            phase_end <= '0;
        end else begin
            phase_end <= '0;
            case (phase)
                PH_IDLE: begin
                    if (start_cmd) begin
                        phase  <= PH_WASH;
                        remain <= wash_ticks(settings);
                    end
                end
                PH_WASH: begin
                    if (last_tick) begin
                        phase               <= PH_RINSE;
                        remain              <= rinse_ticks(settings);
                        phase_end.wash_done <= 1'b1;
                    end else if (tick) begin
                        remain <= remain - 1'b1;
                    end
                end
                PH_RINSE: begin
                    if (last_tick) begin
                        phase                <= PH_SPIN;
                        remain               <= spin_ticks(settings);
                        phase_end.rinse_done <= 1'b1;
                    end else if (tick) begin
                        remain <= remain - 1'b1;
                    end
                end
                PH_SPIN: begin
                    if (last_tick) begin
                        phase               <= PH_IDLE;   // run complete
                        remain              <= '0;
                        phase_end.spin_done <= 1'b1;
                    end else if (tick) begin
                        remain <= remain - 1'b1;
                    end
                end
                default: begin
                    phase  <= PH_IDLE;
                    remain <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- washer_ring.sv
`timescale 1ns/1ps
`default_nettype none

module washer_ring #(
    parameter int KEY_BEEPS   = 2,
    parameter int PHASE_BEEPS = 6
) (
    input  wire logic                    clk_src,
    input  wire logic                    arst_n,
    input  wire logic                    power,
    input  wire logic                    key_press,
    input  wire washer_pkg::phase_end_t  phase_end,
    input  wire logic                    tick,
    output logic                         alarm
);

    localparam int BEEP_MAX = (KEY_BEEPS > PHASE_BEEPS) ? KEY_BEEPS : PHASE_BEEPS;
    localparam int CNT_W    = $clog2(BEEP_MAX + 1);

    typedef enum logic [1:0] {
        RING_QUIET = 2'd0,
        RING_KEY   = 2'd1,
        RING_PHASE = 2'd2
    } ring_state_e;

    ring_state_e      state;
    logic [CNT_W-1:0] beep_cnt;          // toggles so far
    logic [CNT_W-1:0] beep_last;
    logic             any_end;
    logic             beep_done;

    assign any_end   = |phase_end;
    assign beep_last = (state == RING_KEY) ? CNT_W'(KEY_BEEPS - 1) : CNT_W'(PHASE_BEEPS - 1);
    assign beep_done = tick && (beep_cnt == beep_last);

    ////////////////////////////////////////////////////////////////////////////
    // buzzer state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_src or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RING_QUIET;
            beep_cnt <= '0;
            alarm    <= 1'b0;
        end else if (!power) begin
            state    <= RING_QUIET;
            beep_cnt <= '0;
            alarm    <= 1'b0;
        end else begin
            case (state)
                RING_QUIET: begin
                    if (key_press) begin
                        state    <= RING_KEY;
                        beep_cnt <= '0;
                    end else if (any_end) begin
                        state    <= RING_PHASE;
                        beep_cnt <= '0;
                    end
                end
                RING_KEY: begin
                    if (any_end) begin
                        state    <= RING_PHASE;   // phase end overrides key beep
                        beep_cnt <= '0;
                    end else if (beep_done) begin
                        state    <= RING_QUIET;
                        beep_cnt <= '0;
                        alarm    <= 1'b0;
                    end else if (tick) begin
                        beep_cnt <= beep_cnt + 1'b1;
                        alarm    <= ~alarm;
                    end
                end
                RING_PHASE: begin
                    if (key_press) begin
                        state    <= RING_KEY;     // restart as short beep
                        beep_cnt <= '0;
                    end else if (beep_done) begin
                        state    <= RING_QUIET;
                        beep_cnt <= '0;
                        alarm    <= 1'b0;
                    end else if (tick) begin
                        beep_cnt <= beep_cnt + 1'b1;
                        alarm    <= ~alarm;
                    end
                end
                default: begin
                    state    <= RING_QUIET;
                    beep_cnt <= '0;
                    alarm    <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- washer_top.sv
`timescale 1ns/1ps
`default_nettype none

module washer_top #(
    parameter int TICK_DIV    = 8,
    parameter int KEY_BEEPS   = washer_pkg::KEY_BEEP_TICKS,
    parameter int PHASE_BEEPS = washer_pkg::PHASE_BEEP_TICKS
) (
    input  wire logic                  clk_src,
    input  wire logic                  arst_n,
    input  wire logic                  power,
    input  wire washer_pkg::buttons_t  btn,
    output washer_pkg::status_t        status,
    output logic                       alarm,
    output washer_pkg::phase_end_t     phase_end
);

    import washer_pkg::*;

    settings_t settings;
    phase_e    phase;
    logic      busy;
    logic      key_press;
    logic      start_cmd;
    logic      tick;

    washer_panel panel_i (
        .clk_src   (clk_src),
        .arst_n    (arst_n),
        .power     (power),
        .btn       (btn),
        .busy      (busy),
        .settings  (settings),
        .key_press (key_press),
        .start_cmd (start_cmd)
    );

    washer_phase_seq #(
        .TICK_DIV (TICK_DIV)
    ) seq_i (
        .clk_src   (clk_src),
        .arst_n    (arst_n),
        .power     (power),
        .start_cmd (start_cmd),
        .settings  (settings),
        .phase     (phase),
        .busy      (busy),
        .tick      (tick),             // shared with buzzer
        .phase_end (phase_end)
    );

    washer_ring #(
        .KEY_BEEPS   (KEY_BEEPS),
        .PHASE_BEEPS (PHASE_BEEPS)
    ) ring_i (
        .clk_src   (clk_src),
        .arst_n    (arst_n),
        .power     (power),
        .key_press (key_press),
        .phase_end (phase_end),
        .tick      (tick),
        .alarm     (alarm)
    );

    assign status = '{settings: settings, phase: phase, busy: busy};

endmodule

`default_nettype wire

//--- tb_washer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_washer;

    import washer_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int STIM_DELAY   = 1;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_CYCLES   = 6000;
    localparam int TICK_DIV     = 4;
    localparam int KEY_BEEPS    = KEY_BEEP_TICKS;
    localparam int PHASE_BEEPS  = PHASE_BEEP_TICKS;

    localparam logic [1:0] P_IDLE  = 2'd0;
    localparam logic [1:0] P_WASH  = 2'd1;
    localparam logic [1:0] P_RINSE = 2'd2;
    localparam logic [1:0] P_SPIN  = 2'd3;

    localparam int R_QUIET = 0;
    localparam int R_KEY   = 1;
    localparam int R_PHASE = 2;

    logic       clk_src;
    logic       arst_n;
    logic       power;
    buttons_t   btn;
    status_t    status;
    logic       alarm;
    phase_end_t phase_end;

    // reference model state
    logic [1:0]  m_mode;
    logic [1:0]  m_weight;
    logic [1:0]  m_phase;
    logic        m_key;
    logic        m_start;
    logic        m_tick;
    logic [2:0]  m_pend;                 // wash, rinse, spin
    logic        m_alarm;
    int          m_div;
    int          m_remain;
    int          m_ring;
    int          m_bcnt;

    logic [31:0] rng = 32'h4f8009d0;
    int          off_left;
    int          runs_done;
    int          key_beeps;
    int          phase_beeps;

    washer_top #(
        .TICK_DIV (TICK_DIV)
    ) dut_i (
        .clk_src   (clk_src),
        .arst_n    (arst_n),
        .power     (power),
        .btn       (btn),
        .status    (status),
        .alarm     (alarm),
        .phase_end (phase_end)
    );

    initial begin
        clk_src = 1'b0;
        forever #(CLK_PERIOD / 2) clk_src = ~clk_src;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // durations in ticks
    function automatic int wash_len(input logic [1:0] mode, input logic [1:0] weight);
        int units;
        units = int'(weight) + 1;
        if (mode == 2'd1) begin
            return units;
        end else if (mode == 2'd2) begin
            return units * 3;
        end
        return units * 2;                // standard and code 3
    endfunction

    function automatic int rinse_len(input logic [1:0] weight);
        return int'(weight) + 2;
    endfunction

    function automatic int spin_len(input logic [1:0] mode);
        return (mode == 2'd1) ? 2 : 3;
    endfunction

    task automatic reset_model();
        m_mode   = 2'd0;
        m_weight = 2'd0;
        m_phase  = P_IDLE;
        m_key    = 1'b0;
        m_start  = 1'b0;
        m_tick   = 1'b0;
        m_pend   = 3'b000;
        m_alarm  = 1'b0;
        m_div    = 0;
        m_remain = 0;
        m_ring   = R_QUIET;
        m_bcnt   = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // cycle model, one call per rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic step_model();
        logic [1:0] n_mode;
        logic [1:0] n_weight;
        logic [1:0] n_phase;
        logic       n_key;
        logic       n_start;
        logic       n_tick;
        logic [2:0] n_pend;
        logic       n_alarm;
        int         n_div;
        int         n_remain;
        int         n_ring;
        int         n_bcnt;
        int         limit;
        n_mode   = m_mode;
        n_weight = m_weight;
        n_phase  = m_phase;
        n_key    = 1'b0;
        n_start  = 1'b0;
        n_tick   = 1'b0;
        n_pend   = 3'b000;
        n_alarm  = m_alarm;
        n_div    = m_div;
        n_remain = m_remain;
        n_ring   = m_ring;
        n_bcnt   = m_bcnt;
        if (!power) begin
            n_mode   = 2'd0;
            n_weight = 2'd0;
            n_phase  = P_IDLE;
            n_div    = 0;
            n_remain = 0;
            n_ring   = R_QUIET;
            n_bcnt   = 0;
            n_alarm  = 1'b0;
        end else begin
            // panel
            if (m_phase == P_IDLE) begin
                if (btn.start_btn) begin
                    n_start = 1'b1;
                    n_key   = 1'b1;
                end else if (btn.mode_btn || btn.weight_btn) begin
                    n_key = 1'b1;
                    if (btn.mode_btn) begin
                        n_mode = (m_mode == 2'd1) ? 2'd2 : ((m_mode == 2'd2) ? 2'd0 : 2'd1);
                    end
                    if (btn.weight_btn) begin
                        n_weight = m_weight + 2'd1;
                    end
                end
            end
            // prescaler
            if (m_div == TICK_DIV - 1) begin
                n_div  = 0;
                n_tick = 1'b1;
            end else begin
                n_div = m_div + 1;
            end
            // phase timer
            if (m_phase == P_IDLE) begin
                if (m_start) begin
                    n_phase  = P_WASH;
                    n_remain = wash_len(m_mode, m_weight);
                end
            end else if (m_tick && m_remain == 1) begin
                if (m_phase == P_WASH) begin
                    n_phase  = P_RINSE;
                    n_remain = rinse_len(m_weight);
                    n_pend   = 3'b100;
                end else if (m_phase == P_RINSE) begin
                    n_phase  = P_SPIN;
                    n_remain = spin_len(m_mode);
                    n_pend   = 3'b010;
                end else if (m_phase == P_SPIN) begin
                    n_phase   = P_IDLE;
                    n_remain  = 0;
                    n_pend    = 3'b001;
                    runs_done = runs_done + 1;
                end
            end else if (m_tick) begin
                n_remain = m_remain - 1;
            end
            // buzzer
            if (m_ring == R_QUIET) begin
                if (m_key) begin
                    n_ring = R_KEY;
                    n_bcnt = 0;
                end else if (m_pend != 3'b000) begin
                    n_ring = R_PHASE;
                    n_bcnt = 0;
                end
            end else if (m_ring == R_KEY && m_pend != 3'b000) begin
                n_ring = R_PHASE;
                n_bcnt = 0;
            end else if (m_ring == R_PHASE && m_key) begin
                n_ring = R_KEY;
                n_bcnt = 0;
            end else if (m_tick) begin
                limit = (m_ring == R_KEY) ? KEY_BEEPS : PHASE_BEEPS;
                if (m_bcnt + 1 == limit) begin
                    if (m_ring == R_KEY) begin
                        key_beeps = key_beeps + 1;
                    end else begin
                        phase_beeps = phase_beeps + 1;
                    end
                    n_ring  = R_QUIET;
                    n_bcnt  = 0;
                    n_alarm = 1'b0;
                end else begin
                    n_bcnt  = m_bcnt + 1;
                    n_alarm = ~m_alarm;
                end
            end
        end
        m_mode   = n_mode;
        m_weight = n_weight;
        m_phase  = n_phase;
        m_key    = n_key;
        m_start  = n_start;
        m_tick   = n_tick;
        m_pend   = n_pend;
        m_alarm  = n_alarm;
        m_div    = n_div;
        m_remain = n_remain;
        m_ring   = n_ring;
        m_bcnt   = n_bcnt;
    endtask

    task automatic check_outputs();
        logic [6:0] exp_status;
        exp_status = {m_mode, m_weight, m_phase, m_phase != P_IDLE};
        assert (status === exp_status) else begin
            $display("Error: status got 0x%h expected 0x%h", status, exp_status);
            abort_run("status mismatch");
        end
        assert (alarm === m_alarm) else begin
            $display("Error: alarm got 0x%h expected 0x%h", alarm, m_alarm);
            abort_run("alarm mismatch");
        end
        assert (phase_end === m_pend) else begin
            $display("Error: phase_end got 0x%h expected 0x%h", phase_end, m_pend);
            abort_run("phase_end mismatch");
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r_pwr;
        logic [31:0] r_btn;
        rng   = lcg_next(rng);
        r_pwr = rng;
        rng   = lcg_next(rng);
        r_btn = rng;
        if (off_left != 0) begin
            power    = 1'b0;
            off_left = off_left - 1;
        end else if (r_pwr[31:22] == 10'd0) begin
            power    = 1'b0;             // drop of one to four cycles
            off_left = int'(r_pwr[21:20]);
        end else begin
            power = 1'b1;
        end
        if (r_btn[31:27] == 5'd0) begin
            btn = buttons_t'(r_btn[26:24]);
        end else begin
            btn = '0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int cyc;
        arst_n      = 1'b0;
        power       = 1'b1;
        btn         = '0;
        off_left    = 0;
        runs_done   = 0;
        key_beeps   = 0;
        phase_beeps = 0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk_src);
        #STIM_DELAY;
        arst_n = 1'b1;
        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk_src);
            #STIM_DELAY;
            step_model();
            check_outputs();
            drive_inputs();
        end
        if (runs_done > 0 && key_beeps > 0 && phase_beeps > 0) begin
            $display("runs %0d, key beeps %0d, phase beeps %0d", runs_done, key_beeps,
                     phase_beeps);
            $display("All checks passed");
            $finish;
        end else begin
            abort_run("the random run did not complete a wash cycle, a key beep and a phase beep");
        end
    end

    initial begin
        #((NUM_CYCLES + 200) * CLK_PERIOD);
        abort_run("timeout: the simulation did not reach its end in time");
    end

endmodule

`default_nettype wire

//--- all.f
washer_pkg.sv
washer_panel.sv
washer_phase_seq.sv
washer_ring.sv
washer_top.sv
tb_washer.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_washer -f all.f -o tb_washer_sim

# a failing run exits nonzero, the output search below gives the verdict
sim_out=$(./obj_dir/tb_washer_sim 2>&1 || true)
echo "$sim_out"

echo "$sim_out" | grep -q "^All checks passed$"
echo "simulation passed"
